// ==== design/busCycleUnit.sv ====
// ---------------------------------------------------------------------------
// Bus cycle unit top level. Joins the decode, execute and result stages
// between the core request port and the external bus pins.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module busCycleUnit (
    input  logic                            setM1,
    input  logic                            reset,
    // Core side
    input  logic                            reqValid,
    input  busPkg::busFunc                  reqFunc,
    input  logic [busPkg::ADDR_WIDTH-1:0]   reqAddr,
    input  logic [busPkg::DATA_WIDTH-1:0]   reqData,
    output logic                            reqCredit,
    output logic                            rspValid,
    output logic [busPkg::DATA_WIDTH-1:0]   rspData,
    // Bus pins, positive logic
    input  logic                            mwait,
    input  logic                            busrq,
    input  logic [busPkg::DATA_WIDTH-1:0]   dataIn,
    output logic                            m1,
    output logic                            mreq,
    output logic                            iorq,
    output logic                            rd,
    output logic                            wr,
    output logic                            rfsh,
    output logic                            busack,
    output logic [busPkg::ADDR_WIDTH-1:0]   address,
    output logic [busPkg::DATA_WIDTH-1:0]   dataOut,
    output logic                            addrOe,
    output logic                            ctrlOe,
    output logic                            dataOe
);

    logic                            curValid;
    busPkg::busFunc                  curFunc;
    logic [busPkg::ADDR_WIDTH-1:0]   curAddr;
    logic [busPkg::DATA_WIDTH-1:0]   curData;
    logic                            cycleStart;
    busPkg::tState                   state;
    busPkg::busFunc                  func;

    // Decode stage
    cycleDecode decode (
        .setM1, .reset, .reqValid, .reqFunc, .reqAddr, .reqData, .cycleStart,
        .curValid, .curFunc, .curAddr, .curData, .reqCredit
    );

    // Execute stage
    tStateSequencer sequencer (
        .setM1, .reset, .curValid, .curFunc, .mwait, .busrq,
        .state, .func, .cycleStart, .busack
    );

    pinControl pins (
        .setM1, .reset, .state, .func, .busack, .curAddr, .curData,
        .m1, .mreq, .iorq, .rd, .wr, .rfsh, .address, .dataOut,
        .addrOe, .ctrlOe, .dataOe
    );

    // Result stage
    readCapture capture (
        .setM1, .reset, .state, .func, .dataIn, .rspValid, .rspData
    );

endmodule

// ==== design/busPkg.sv ====
// ---------------------------------------------------------------------------
// Shared definitions for the bus cycle unit: bus widths, request queue depth,
// bus function codes and the T-state encoding. Every design file and the
// testbench refer to these by scoped names.
// ---------------------------------------------------------------------------
package busPkg;

    localparam int ADDR_WIDTH = 16;          // Address pins
    localparam int DATA_WIDTH = 8;           // Data pins
    localparam int REQ_DEPTH  = 2;           // Queue entries, also starting credits

    // Bus functions requested by the core
    typedef enum logic [2:0] {
        FETCH   = 3'd0,                      // Opcode fetch, M1 cycle
        MREAD   = 3'd1,                      // Memory read
        MWRITE  = 3'd2,                      // Memory write
        IOREAD  = 3'd3,                      // I/O read
        IOWRITE = 3'd4,                      // I/O write
        INTACK  = 3'd5                       // Interrupt acknowledge
    } busFunc;

    // T-states of the sequencer
    typedef enum logic [2:0] {
        IDLE = 3'd0,
        T1   = 3'd1,
        T2   = 3'd2,
        TWA  = 3'd3,                         // Automatic wait state
        TW   = 3'd4,                         // Wait state from the WAIT pin
        T3   = 3'd5,
        T4   = 3'd6,
        HOLD = 3'd7                          // Bus granted to another master
    } tState;

    // Final T-state of each function
    function automatic tState lastState(input busFunc f);
        case (f)
            MREAD, MWRITE, IOREAD, IOWRITE: return T3;
            default:                        return T4;   // FETCH and INTACK
        endcase
    endfunction

endpackage

// ==== design/cycleDecode.sv ====
// ---------------------------------------------------------------------------
// Decode stage. Queues core requests in a small FIFO, stores each function
// as a class descriptor and presents the head entry to the sequencer.
// A credit goes back to the core whenever a cycle takes the head entry.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module cycleDecode (
    input  logic                            setM1,
    input  logic                            reset,
    input  logic                            reqValid,    // One clock per request
    input  busPkg::busFunc                  reqFunc,
    input  logic [busPkg::ADDR_WIDTH-1:0]   reqAddr,
    input  logic [busPkg::DATA_WIDTH-1:0]   reqData,
    input  logic                            cycleStart,  // T1 clock of a new cycle
    output logic                            curValid,
    output busPkg::busFunc                  curFunc,
    output logic [busPkg::ADDR_WIDTH-1:0]   curAddr,
    output logic [busPkg::DATA_WIDTH-1:0]   curData,
    output logic                            reqCredit
);

    // Descriptor bits {m1Cycle, ioSpace, writeDir}
    logic [2:0]                      descQ [busPkg::REQ_DEPTH];
    logic [busPkg::ADDR_WIDTH-1:0]   addrQ [busPkg::REQ_DEPTH];
    logic [busPkg::DATA_WIDTH-1:0]   dataQ [busPkg::REQ_DEPTH];
    logic [$clog2(busPkg::REQ_DEPTH)-1:0] wrPtr, rdPtr;
    logic [$clog2(busPkg::REQ_DEPTH):0]   count;
    logic                            pop;
    logic [2:0]                      headDesc;

    // Classify a function into cycle kind, address space and direction
    function automatic logic [2:0] encodeDesc(input busPkg::busFunc f);
        logic m1Cycle;
        logic ioSpace;
        logic writeDir;
        m1Cycle  = (f == busPkg::FETCH) || (f == busPkg::INTACK);
        ioSpace  = (f == busPkg::IOREAD) || (f == busPkg::IOWRITE) || (f == busPkg::INTACK);
        writeDir = (f == busPkg::MWRITE) || (f == busPkg::IOWRITE);
        return {m1Cycle, ioSpace, writeDir};
    endfunction

    assign pop       = cycleStart && (count != '0);
    assign reqCredit = pop;                          // One credit per started cycle
    assign curValid  = (count != '0);
    assign headDesc  = descQ[rdPtr];
    assign curAddr   = addrQ[rdPtr];
    assign curData   = dataQ[rdPtr];

    // Rebuild the function from the head descriptor
    always_comb begin
        case (headDesc)
            3'b100:  curFunc = busPkg::FETCH;
            3'b110:  curFunc = busPkg::INTACK;
            3'b001:  curFunc = busPkg::MWRITE;
            3'b010:  curFunc = busPkg::IOREAD;
            3'b011:  curFunc = busPkg::IOWRITE;
            default: curFunc = busPkg::MREAD;
        endcase
    end

    // Queue storage
    always_ff @(posedge setM1) begin
        if (reqValid) begin
            descQ[wrPtr] <= encodeDesc(reqFunc);
            addrQ[wrPtr] <= reqAddr;
            dataQ[wrPtr] <= reqData;
        end
    end

    // Pointers and occupancy, credits keep the queue from overflowing
    always_ff @(posedge setM1) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (reqValid) wrPtr <= wrPtr + 1'b1;
            if (pop)      rdPtr <= rdPtr + 1'b1;
            count <= count + reqValid - pop;
        end
    end

endmodule

// ==== design/pinControl.sv ====
// ---------------------------------------------------------------------------
// Execute stage pin driver. Registers the bus control pins from the next
// T-state so they change together with the sequencer state, latches address
// and write data at T1 and keeps the 7-bit refresh counter.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module pinControl (
    input  logic                            setM1,
    input  logic                            reset,
    input  busPkg::tState                   state,    // Next T-state
    input  busPkg::busFunc                  func,     // Next function
    input  logic                            busack,
    input  logic [busPkg::ADDR_WIDTH-1:0]   curAddr,
    input  logic [busPkg::DATA_WIDTH-1:0]   curData,
    output logic                            m1,
    output logic                            mreq,
    output logic                            iorq,
    output logic                            rd,
    output logic                            wr,
    output logic                            rfsh,
    output logic [busPkg::ADDR_WIDTH-1:0]   address,
    output logic [busPkg::DATA_WIDTH-1:0]   dataOut,
    output logic                            addrOe,
    output logic                            ctrlOe,
    output logic                            dataOe
);

    logic [6:0] refreshCnt;
    logic       refreshDone;                  // High in the final T4 of FETCH or INTACK
    logic       isFetch, isIntack, isMem, isIo, isWrite;

    assign isFetch  = (func == busPkg::FETCH);
    assign isIntack = (func == busPkg::INTACK);
    assign isMem    = (func == busPkg::MREAD) || (func == busPkg::MWRITE);
    assign isIo     = (func == busPkg::IOREAD) || (func == busPkg::IOWRITE);
    assign isWrite  = (func == busPkg::MWRITE) || (func == busPkg::IOWRITE);

    // Pads go quiet while another master owns the bus
    assign addrOe = !busack;
    assign ctrlOe = !busack;

    // ------------------------------------------------------------------------
    // Control pins
    // ------------------------------------------------------------------------
    always_ff @(posedge setM1) begin
        if (reset) begin
            m1          <= 1'b0;
            mreq        <= 1'b0;
            iorq        <= 1'b0;
            rd          <= 1'b0;
            wr          <= 1'b0;
            rfsh        <= 1'b0;
            dataOe      <= 1'b0;
            refreshDone <= 1'b0;
            refreshCnt  <= '0;
        end else begin
            m1   <= (isFetch || isIntack) && (state inside {busPkg::T1, busPkg::T2});
            mreq <= (isMem && (state inside {busPkg::T1, busPkg::T2, busPkg::TW, busPkg::T3}))
                 || (isFetch && (state inside {busPkg::T1, busPkg::T2, busPkg::TW,
                                               busPkg::T3, busPkg::T4}))
                 || (isIntack && (state inside {busPkg::T1, busPkg::T2}));
            iorq <= (isIo && (state inside {busPkg::T2, busPkg::TWA, busPkg::TW, busPkg::T3}))
                 || (isIntack && (state inside {busPkg::TWA, busPkg::TW}));
            rd   <= (isFetch && (state inside {busPkg::T1, busPkg::T2, busPkg::TW}))
                 || ((func == busPkg::MREAD)
                     && (state inside {busPkg::T1, busPkg::T2, busPkg::TW, busPkg::T3}))
                 || ((func == busPkg::IOREAD)
                     && (state inside {busPkg::T2, busPkg::TWA, busPkg::TW, busPkg::T3}));
            wr   <= isWrite && (state inside {busPkg::T2, busPkg::TWA, busPkg::TW, busPkg::T3});
            rfsh <= isFetch && (state inside {busPkg::T3, busPkg::T4});
            // Write data driven for the whole write cycle
            dataOe <= isWrite && (state inside {busPkg::T1, busPkg::T2, busPkg::TWA,
                                                busPkg::TW, busPkg::T3});
            refreshDone <= (state == busPkg::T4) && (isFetch || isIntack);
            if (refreshDone) refreshCnt <= refreshCnt + 7'd1;   // Once per M1 cycle
        end
    end

    // Address and write data latches
    always_ff @(posedge setM1) begin
        if (state == busPkg::T1) begin
            address <= curAddr;
            dataOut <= curData;
        end else if (state == busPkg::T3 && isFetch) begin
            address <= {{(busPkg::ADDR_WIDTH-7){1'b0}}, refreshCnt};   // Refresh address
        end
    end

endmodule

// ==== design/readCapture.sv ====
// ---------------------------------------------------------------------------
// Result stage. Finds the last clock before the read strobe falls, samples
// the data pins at its closing edge and returns one response per read cycle.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module readCapture (
    input  logic                            setM1,
    input  logic                            reset,
    input  busPkg::tState                   state,    // Next T-state
    input  busPkg::busFunc                  func,     // Next function
    input  logic [busPkg::DATA_WIDTH-1:0]   dataIn,
    output logic                            rspValid,
    output logic [busPkg::DATA_WIDTH-1:0]   rspData
);

    busPkg::tState  stateQ;                   // Current T-state
    busPkg::busFunc funcQ;                    // Current function
    logic           sampleNow;

    // FETCH ends its strobe before T3, INTACK before T4
    assign sampleNow = ((funcQ == busPkg::FETCH) && (state == busPkg::T3))
                    || (((funcQ == busPkg::MREAD) || (funcQ == busPkg::IOREAD))
                        && (stateQ == busPkg::T3))
                    || ((funcQ == busPkg::INTACK) && (state == busPkg::T4));

    always_ff @(posedge setM1) begin
        if (reset) begin
            stateQ   <= busPkg::IDLE;
            funcQ    <= busPkg::FETCH;
            rspValid <= 1'b0;
        end else begin
            stateQ   <= state;
            funcQ    <= func;
            rspValid <= sampleNow;
        end
    end

    always_ff @(posedge setM1) begin
        if (sampleNow) rspData <= dataIn;     // Data pins at the sampling edge
    end

endmodule

// ==== design/tStateSequencer.sv ====
// ---------------------------------------------------------------------------
// Execute stage sequencer. Steps each bus cycle through its T-states, adds
// the automatic wait states of I/O and interrupt cycles, stretches cycles
// while WAIT is high and grants the bus on BUSRQ at cycle boundaries.
// The state and function outputs are the values loaded at the next edge.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tStateSequencer (
    input  logic            setM1,
    input  logic            reset,
    input  logic            curValid,     // Queue holds a request
    input  busPkg::busFunc  curFunc,
    input  logic            mwait,        // WAIT pin, high means not ready
    input  logic            busrq,        // BUSRQ pin
    output busPkg::tState   state,        // Next T-state
    output busPkg::busFunc  func,         // Function of the next T-state
    output logic            cycleStart,   // High in T1
    output logic            busack
);

    busPkg::tState   stateQ;
    busPkg::busFunc  funcQ;
    logic            prevTwa;             // Last clock was a TWA
    logic            autoWait;            // Function has automatic wait states
    busPkg::tState   boundaryNext;        // Choice at a cycle boundary
    busPkg::tState   afterWait;           // State that follows the wait window

    assign autoWait = (funcQ == busPkg::IOREAD) || (funcQ == busPkg::IOWRITE) ||
                      (funcQ == busPkg::INTACK);
    assign afterWait = (funcQ == busPkg::INTACK) ? busPkg::T4 : busPkg::T3;

    // BUSRQ wins over a queued request
    always_comb begin
        if (busrq)         boundaryNext = busPkg::HOLD;
        else if (curValid) boundaryNext = busPkg::T1;
        else               boundaryNext = busPkg::IDLE;
    end

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    always_comb begin
        case (stateQ)
            busPkg::T1: state = busPkg::T2;
            busPkg::T2: begin
                if (autoWait)   state = busPkg::TWA;
                else if (mwait) state = busPkg::TW;    // Memory cycles sample WAIT here
                else            state = busPkg::T3;
            end
            busPkg::TWA: begin
                if (funcQ == busPkg::INTACK && !prevTwa) state = busPkg::TWA;
                else if (mwait)                          state = busPkg::TW;
                else                                     state = afterWait;
            end
            busPkg::TW:   state = mwait ? busPkg::TW : afterWait;
            busPkg::T3: begin
                if (busPkg::lastState(funcQ) == busPkg::T3) state = boundaryNext;
                else                                         state = busPkg::T4;
            end
            busPkg::T4:   state = boundaryNext;
            busPkg::HOLD: state = busrq ? busPkg::HOLD : busPkg::IDLE;
            default:      state = boundaryNext;                // IDLE
        endcase
    end

    // Function is taken from the queue head when a cycle starts
    assign func = (state == busPkg::T1) ? curFunc : funcQ;

    always_ff @(posedge setM1) begin
        if (reset) begin
            stateQ     <= busPkg::IDLE;
            funcQ      <= busPkg::FETCH;
            prevTwa    <= 1'b0;
            cycleStart <= 1'b0;
            busack     <= 1'b0;
        end else begin
            stateQ     <= state;
            funcQ      <= func;
            prevTwa    <= (stateQ == busPkg::TWA);
            cycleStart <= (state == busPkg::T1);      // Pops the queue at end of T1
            busack     <= (state == busPkg::HOLD);
        end
    end

endmodule

// ==== flist.f ====
design/busPkg.sv
design/cycleDecode.sv
design/tStateSequencer.sv
design/pinControl.sv
design/readCapture.sv
design/busCycleUnit.sv
test/memoryModel.sv
test/busCycleTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the bus cycle unit testbench with Verilator and run it.
# The run counts as passed only if the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module busCycleTb -o busCycleSim &&
./obj_dir/busCycleSim | tee /dev/stderr | grep -q "Regression passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// ==== test/busCycleTb.sv ====
// ---------------------------------------------------------------------------
// Directed testbench for the bus cycle unit. Plays the core side with
// credits, watches the bus pins at the falling edge and checks reads,
// writes, I/O, interrupt acknowledge, WAIT, BUSRQ and credit flow.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module busCycleTb;

    logic setM1 = 1'b0, reset, reqValid, busrq, reqCredit, rspValid, mwait;
    logic m1, mreq, iorq, rd, wr, rfsh, busack, addrOe, ctrlOe, dataOe;
    busPkg::busFunc reqFunc;
    logic [15:0] reqAddr, address, refreshAddr;
    logic [7:0]  reqData, rspData, dataIn, dataOut;
    logic [3:0]  waitCount;
    logic [7:0]  rspQ [$];                       // Responses in arrival order
    logic        sawM1, sawMreq, sawIorq, prevRfsh = 1'b0;
    int errors = 0, checks = 0, tests = 0, cycles = 0, pulses = 0, sent = 0;
    int credits, refreshExp = 0, mreqRun = 0, iorqRun = 0, mreqLen = 0, iorqLen = 0;
    integer seed = 32'h59b0;

    busCycleUnit dut (.*);
    memoryModel mem (.setM1, .reset, .mreq, .iorq, .rd, .wr, .address, .dataOut,
                     .waitCount, .mwait, .dataIn);

    always #20 setM1 = ~setM1;                   // 40 ns period

    // Watchdog that ends a hung run
    always @(posedge setM1) begin
        cycles++;
        if (cycles >= 2000) begin
            $display("Timeout: the tests did not finish within 2000 clocks");
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Pin monitor on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge setM1) begin
        if (rspValid) rspQ.push_back(rspData);
        if (reqCredit) begin
            credits++;                           // Credit back to the core
            pulses++;
        end
        if (m1)   sawM1 = 1'b1;
        if (mreq) sawMreq = 1'b1;
        if (iorq) sawIorq = 1'b1;
        if (rfsh && !prevRfsh) refreshAddr = address;
        prevRfsh = rfsh;
        if (mreq) mreqRun++;
        else if (mreqRun != 0) begin
            mreqLen = mreqRun;
            mreqRun = 0;
        end
        if (iorq) iorqRun++;
        else if (iorqRun != 0) begin
            iorqLen = iorqRun;
            iorqRun = 0;
        end
        assert (!(rd && wr)) else begin
            $display("rd and wr were high in the same clock");
            errors++;
        end
        assert (!wr || dataOe) else begin
            $display("wr was high while the data pads were off");
            errors++;
        end
    end

    function automatic logic [7:0] expectedData(input logic [15:0] a);
        return (a[15:8] ^ a[7:0]) + 8'd1;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] exp, act);
        checks++;
        assert (exp === act) else begin
            $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    // Called at a rising edge and returns one edge after the request
    task automatic sendReq(input busPkg::busFunc f, input logic [15:0] a,
                           input logic [7:0] d);
        while (credits == 0) @(posedge setM1);
        reqValid <= 1'b1;
        reqFunc  <= f;
        reqAddr  <= a;
        reqData  <= d;
        credits--;
        sent++;
        @(posedge setM1);
        reqValid <= 1'b0;
    endtask

    task automatic waitRsp(input int n);
        while (rspQ.size() < n) @(posedge setM1);
    endtask

    task automatic waitQuiet();                  // Strobes low and seen by the monitor
        do @(posedge setM1); while (mreq || iorq || wr);
        @(posedge setM1);
    endtask

    task automatic readCycle(input string name, input busPkg::busFunc f, input int len);
        logic [15:0] a;
        a = $random(seed);
        sawMreq = 1'b0;
        sawIorq = 1'b0;
        sawM1   = 1'b0;
        sendReq(f, a, 8'h00);
        waitRsp(1);
        checkValue({name, " data"}, expectedData(a), rspQ.pop_front());
        waitQuiet();
        if (f == busPkg::IOREAD || f == busPkg::INTACK)
            checkValue({name, " iorq length"}, len, iorqLen);
        else
            checkValue({name, " mreq length"}, len, mreqLen);
    endtask

    task automatic writeCycle(input string name, input busPkg::busFunc f, input int len);
        logic [15:0] a;
        logic [7:0]  d;
        int          old;
        a = $random(seed);
        d = $random(seed);
        old = mem.logAddr.size();
        sawMreq = 1'b0;
        sendReq(f, a, d);
        while (mem.logAddr.size() == old) @(posedge setM1);
        waitQuiet();
        checkValue({name, " address"}, a, mem.logAddr[old]);
        checkValue({name, " data"}, d, mem.logData[old]);
        checkValue({name, " length"}, len, (f == busPkg::IOWRITE) ? iorqLen : mreqLen);
    endtask

    task automatic finishTest(input string name, input int errBefore);
        tests++;
        $display("%s: %s", name, (errors == errBefore) ? "ok" : "FAILED");
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic memReadFetchTest();
        int eb = errors;
        repeat (3) readCycle("memRead", busPkg::MREAD, 3);
        repeat (2) begin
            readCycle("fetch", busPkg::FETCH, 4);
            checkValue("refresh address", refreshExp, refreshAddr);
            refreshExp++;                        // One step per M1 cycle
        end
        finishTest("memReadFetch", eb);
    endtask

    task automatic memWriteTest();
        int eb = errors;
        repeat (2) writeCycle("memWrite", busPkg::MWRITE, 3);
        finishTest("memWrite", eb);
    endtask

    task automatic ioIntackTest();
        int eb = errors;
        readCycle("ioRead", busPkg::IOREAD, 3);
        checkValue("ioRead mreq", 0, sawMreq);
        writeCycle("ioWrite", busPkg::IOWRITE, 3);
        checkValue("ioWrite mreq", 0, sawMreq);
        readCycle("intAck", busPkg::INTACK, 2);
        checkValue("intAck m1", 1, sawM1);
        checkValue("intAck iorq", 1, sawIorq);
        checkValue("intAck mreq length", 2, mreqLen);
        finishTest("ioIntack", eb);
    endtask

    task automatic waitStateTest();
        int eb = errors;
        waitCount <= 4'd2;
        readCycle("waitMemRead", busPkg::MREAD, 3 + 2);
        readCycle("waitIoRead", busPkg::IOREAD, 3 + 2);
        waitCount <= 4'd0;
        finishTest("waitState", eb);
    endtask

    task automatic busRequestTest();
        int eb = errors;
        logic [15:0] a;
        busrq <= 1'b1;
        do @(posedge setM1); while (!busack);
        @(posedge setM1);
        checkValue("hold addrOe", 0, addrOe);
        checkValue("hold ctrlOe", 0, ctrlOe);
        checkValue("hold dataOe", 0, dataOe);
        a = $random(seed);
        sawMreq = 1'b0;
        sendReq(busPkg::MREAD, a, 8'h00);
        repeat (8) @(posedge setM1);             // Request parked behind HOLD
        checkValue("hold strobe", 0, sawMreq);
        busrq <= 1'b0;
        waitRsp(1);
        checkValue("after hold data", expectedData(a), rspQ.pop_front());
        waitQuiet();
        checkValue("busack released", 0, busack);
        finishTest("busRequest", eb);
    endtask

    task automatic creditFlowTest();
        int eb = errors;
        int p0 = pulses;
        logic [15:0] a1, a2;
        a1 = $random(seed);
        a2 = $random(seed);
        sendReq(busPkg::MREAD, a1, 8'h00);
        sendReq(busPkg::IOREAD, a2, 8'h00);      // Second request spends the last credit
        checkValue("credits spent", 0, credits);
        waitRsp(2);
        checkValue("first response", expectedData(a1), rspQ.pop_front());
        checkValue("second response", expectedData(a2), rspQ.pop_front());
        waitQuiet();
        checkValue("credit pulses", 2, pulses - p0);
        checkValue("credits returned", busPkg::REQ_DEPTH, credits);
        finishTest("creditFlow", eb);
    endtask

    initial begin
        reset     = 1'b1;
        reqValid  = 1'b0;
        reqFunc   = busPkg::FETCH;
        reqAddr   = '0;
        reqData   = '0;
        busrq     = 1'b0;
        waitCount = '0;
        credits   = busPkg::REQ_DEPTH;
        repeat (5) @(posedge setM1);
        reset <= 1'b0;
        @(posedge setM1);
        memReadFetchTest();
        memWriteTest();
        ioIntackTest();
        waitStateTest();
        busRequestTest();
        creditFlowTest();
        checkValue("pulses per request", sent, pulses);
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== test/memoryModel.sv ====
// ---------------------------------------------------------------------------
// Behavioral memory and I/O device for the testbench. Returns the XOR of
// the address bytes plus one on reads and interrupt acknowledge, logs each
// write cycle and holds WAIT high for a programmable number of clocks.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module memoryModel (
    input  logic        setM1,
    input  logic        reset,
    input  logic        mreq,
    input  logic        iorq,
    input  logic        rd,
    input  logic        wr,
    input  logic [15:0] address,
    input  logic [7:0]  dataOut,
    input  logic [3:0]  waitCount,           // WAIT clocks per cycle
    output logic        mwait = 1'b0,
    output logic [7:0]  dataIn
);

    logic [15:0] logAddr [$];                // Write log, one entry per wr cycle
    logic [7:0]  logData [$];
    logic        prevMreq, prevIorq, prevWr;
    logic [3:0]  waitLeft;

    function automatic logic [7:0] busValue(input logic [15:0] a);
        return (a[15:8] ^ a[7:0]) + 8'd1;
    endfunction

    // Reads, plus the vector on an acknowledge (iorq without rd or wr)
    assign dataIn = (rd || (iorq && !wr)) ? busValue(address) : 8'h00;

    always @(posedge setM1) begin
        if (reset) begin
            mwait    <= 1'b0;
            waitLeft <= '0;
            prevMreq <= 1'b0;
            prevIorq <= 1'b0;
            prevWr   <= 1'b0;
        end else begin
            prevMreq <= mreq;
            prevIorq <= iorq;
            prevWr   <= wr;
            // Strobe just rose, WAIT covers the next waitCount clocks
            if ((mreq && !prevMreq) || (iorq && !prevIorq)) begin
                waitLeft <= waitCount;
                mwait    <= (waitCount != 0);
            end else begin
                if (waitLeft != 0) waitLeft <= waitLeft - 4'd1;
                mwait <= (waitLeft > 1);
            end
            if (wr && !prevWr) begin             // First clock of the write strobe
                logAddr.push_back(address);
                logData.push_back(dataOut);
            end
        end
    end

endmodule
